//--- build.f
rtl/xcom_cmd_pkg.sv
rtl/xcom_link_pkg.sv
rtl/xcom_cmd_capture.sv
rtl/xcom_cmd_arb.sv
rtl/xcom_loc_exec.sv
rtl/xcom_tx.sv
rtl/xcom_cmd_top.sv
tb/xcom_cmd_sva.sv
tb/tb_xcom_cmd.sv

//--- rtl/xcom_cmd_arb.sv
// picks one pending command, processor first, and drives the local or network request level
`timescale 1ns/1ps

module xcom_cmd_arb (
  input  logic               i_clk,
  input  logic               c_rst_ni,
  // processor capture
  input  logic               i_c_pending,
  input  logic               i_c_is_net,
  input  xcom_cmd_pkg::cmd_t i_c_cmd,
  // host capture
  input  logic               i_p_pending,
  input  logic               i_p_is_net,
  input  xcom_cmd_pkg::cmd_t i_p_cmd,
  // take pulses back to the captures
  output logic               o_c_take,
  output logic               o_p_take,
  // executors
  output xcom_cmd_pkg::cmd_t o_cmd,
  output logic               o_loc_req,
  output logic               o_net_req,
  input  logic               i_loc_ack,
  input  logic               i_net_ack
);

  import xcom_cmd_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOC,
    ST_NET
  } arb_state_e;

  arb_state_e state_q;
  cmd_t       cmd_q;

  ////////////////////////////////////////////////////////////
  // grant FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!c_rst_ni) begin
      state_q  <= ST_IDLE;
      o_c_take <= 1'b0;
      o_p_take <= 1'b0;
    end else begin
      // take is a single cycle pulse
      o_c_take <= 1'b0;
      o_p_take <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          // processor wins a tie
          if (i_c_pending) begin
            o_c_take <= 1'b1;
            state_q  <= i_c_is_net ? ST_NET : ST_LOC;
          end else if (i_p_pending) begin
            o_p_take <= 1'b1;
            state_q  <= i_p_is_net ? ST_NET : ST_LOC;
          end
        end
        ST_LOC: begin
          if (i_loc_ack) begin
            state_q <= ST_IDLE;
          end
        end
        ST_NET: begin
          // tx busy keeps us here, captures stay pending
          if (i_net_ack) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // copy of the granted command, stable for the whole request
  always_ff @(posedge i_clk) begin
    if (state_q == ST_IDLE) begin
      if (i_c_pending) begin
        cmd_q <= i_c_cmd;
      end else if (i_p_pending) begin
        cmd_q <= i_p_cmd;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // request levels
  ////////////////////////////////////////////////////////////

  // one-hot by construction of the state encoding
  assign o_loc_req = (state_q == ST_LOC);
  assign o_net_req = (state_q == ST_NET);
  assign o_cmd     = cmd_q;

endmodule

//--- rtl/xcom_cmd_capture.sv
// holds one pending command from a single source until the arbiter takes it
`timescale 1ns/1ps

module xcom_cmd_capture #(
  parameter int CNT_W = 4
) (
  input  logic               i_clk,
  input  logic               c_rst_ni,
  // source side
  input  logic               i_vld,
  input  logic [4:0]         i_op,
  input  logic [31:0]        i_data0,
  input  logic [31:0]        i_data1,
  // arbiter side
  input  logic               i_take,
  output logic               o_pending,
  output logic               o_is_net,
  output xcom_cmd_pkg::cmd_t o_cmd,
  output logic [CNT_W-1:0]   o_cnt
);

  import xcom_cmd_pkg::*;

  cmd_op_e          op_in;
  logic             op_ok;
  logic             accept;
  logic [CNT_W-1:0] cnt_q;

  ////////////////////////////////////////////////////////////
  // strobe qualification
  ////////////////////////////////////////////////////////////

  // raw code, unknown values end up rejected below
  assign op_in = cmd_op_e'(i_op);

  // nop and unknown codes never occupy the slot
  assign op_ok = cmd_is_net(op_in) | cmd_is_loc(op_in);

  // slot busy means the strobe is lost
  assign accept = i_vld & ~o_pending & op_ok;

  ////////////////////////////////////////////////////////////
  // slot state and counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!c_rst_ni) begin
      o_pending <= 1'b0;
      o_is_net  <= 1'b0;
      cnt_q     <= '0;
    end else if (accept) begin
      o_pending <= 1'b1;
      o_is_net  <= cmd_is_net(op_in);
      // wraps at 2**CNT_W
      cnt_q     <= cnt_q + CNT_W'(1);
    end else if (i_take) begin
      // arbiter copied the command, slot is free
      o_pending <= 1'b0;
    end
  end

  // payload, only written on accept
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_cmd <= cmd_make(op_in, i_data0, i_data1);
    end
  end

  assign o_cnt = cnt_q;

endmodule

//--- rtl/xcom_cmd_pkg.sv
// command-side definitions shared by the capture, arbiter and executor blocks of the xcom front end
package xcom_cmd_pkg;

  // opcode field as seen on both command sources
  // unlisted codes fall through as nop
  typedef enum logic [4:0] {
    OP_NOP      = 5'd0,
    OP_SET_ID   = 5'd1,
    OP_SET_TICK = 5'd2,
    OP_SEND0    = 5'd4,
    OP_SEND8    = 5'd5,
    OP_SEND16   = 5'd6,
    OP_SEND32   = 5'd7
  } cmd_op_e;

  // one merged command, 41 bits
  typedef struct packed {
    cmd_op_e     op;
    logic [3:0]  dst;
    logic [31:0] data;
  } cmd_t;

  // network sends, low two bits carry the length code
  function automatic logic cmd_is_net(input cmd_op_e op);
    return (op inside {OP_SEND0, OP_SEND8, OP_SEND16, OP_SEND32});
  endfunction

  // register writes handled on this board
  function automatic logic cmd_is_loc(input cmd_op_e op);
    return (op inside {OP_SET_ID, OP_SET_TICK});
  endfunction

  // pack source fields into a command
  function automatic cmd_t cmd_make(input cmd_op_e op, input logic [31:0] data0,
                                    input logic [31:0] data1);
    cmd_t c;
    c.op   = op;
    c.dst  = data0[3:0];
    c.data = data1;
    return c;
  endfunction

endpackage

//--- rtl/xcom_cmd_top.sv
// xcom command front end top level, two sources feed one arbiter and the local and network paths
`timescale 1ns/1ps

module xcom_cmd_top #(
  parameter int CNT_W = 4
) (
  input  logic                  i_clk,
  input  logic                  c_rst_ni,
  // processor source
  input  logic                  i_tproc_en,
  input  logic [4:0]            i_tproc_op,
  input  logic [31:0]           i_tproc_data0,
  input  logic [31:0]           i_tproc_data1,
  // host source, ctrl bit 0 strobe, bits 5:1 opcode
  input  logic [5:0]            i_ps_ctrl,
  input  logic [31:0]           i_ps_data0,
  input  logic [31:0]           i_ps_data1,
  // serial link
  output logic                  o_xcom_data,
  output logic                  o_xcom_clk,
  output logic                  o_ready,
  // link configuration
  output logic [3:0]            o_board_id,
  output xcom_link_pkg::tick_t  o_cfg_tick,
  // processor count high, host count low
  output logic [2*CNT_W-1:0]    o_cmd_cnt
);

  import xcom_cmd_pkg::*;

  logic c_pending, c_is_net, c_take;
  logic p_pending, p_is_net, p_take;
  cmd_t c_cmd, p_cmd, arb_cmd;
  logic loc_req, loc_ack;
  logic net_req, net_ack;

  ////////////////////////////////////////////////////////////
  // source captures
  ////////////////////////////////////////////////////////////

  xcom_cmd_capture #(.CNT_W(CNT_W)) u_cap_tproc (
    .i_clk     (i_clk),
    .c_rst_ni  (c_rst_ni),
    .i_vld     (i_tproc_en),
    .i_op      (i_tproc_op),
    .i_data0   (i_tproc_data0),
    .i_data1   (i_tproc_data1),
    .i_take    (c_take),
    .o_pending (c_pending),
    .o_is_net  (c_is_net),
    .o_cmd     (c_cmd),
    .o_cnt     (o_cmd_cnt[2*CNT_W-1:CNT_W])
  );

  xcom_cmd_capture #(.CNT_W(CNT_W)) u_cap_ps (
    .i_clk     (i_clk),
    .c_rst_ni  (c_rst_ni),
    .i_vld     (i_ps_ctrl[0]),
    .i_op      (i_ps_ctrl[5:1]),
    .i_data0   (i_ps_data0),
    .i_data1   (i_ps_data1),
    .i_take    (p_take),
    .o_pending (p_pending),
    .o_is_net  (p_is_net),
    .o_cmd     (p_cmd),
    .o_cnt     (o_cmd_cnt[CNT_W-1:0])
  );

  ////////////////////////////////////////////////////////////
  // arbiter and executors
  ////////////////////////////////////////////////////////////

  xcom_cmd_arb u_arb (
    .i_clk       (i_clk),
    .c_rst_ni    (c_rst_ni),
    .i_c_pending (c_pending),
    .i_c_is_net  (c_is_net),
    .i_c_cmd     (c_cmd),
    .i_p_pending (p_pending),
    .i_p_is_net  (p_is_net),
    .i_p_cmd     (p_cmd),
    .o_c_take    (c_take),
    .o_p_take    (p_take),
    .o_cmd       (arb_cmd),
    .o_loc_req   (loc_req),
    .o_net_req   (net_req),
    .i_loc_ack   (loc_ack),
    .i_net_ack   (net_ack)
  );

  xcom_loc_exec u_loc (
    .i_clk      (i_clk),
    .c_rst_ni   (c_rst_ni),
    .i_req      (loc_req),
    .i_cmd      (arb_cmd),
    .o_ack      (loc_ack),
    .o_board_id (o_board_id),
    .o_cfg_tick (o_cfg_tick)
  );

  // tick register feeds the divider directly
  xcom_tx u_tx (
    .i_clk       (i_clk),
    .c_rst_ni    (c_rst_ni),
    .i_req       (net_req),
    .i_cmd       (arb_cmd),
    .i_cfg_tick  (o_cfg_tick),
    .o_ack       (net_ack),
    .o_ready     (o_ready),
    .o_xcom_data (o_xcom_data),
    .o_xcom_clk  (o_xcom_clk)
  );

endmodule

//--- rtl/xcom_link_pkg.sv
// serial link definitions used by the xcom transmitter and the link configuration registers
package xcom_link_pkg;

  // payload length code, header bits 6:5
  typedef enum logic [1:0] {
    LEN_NONE = 2'd0,
    LEN_8    = 2'd1,
    LEN_16   = 2'd2,
    LEN_32   = 2'd3
  } len_e;

  // 8-bit header, sent MSB first
  typedef struct packed {
    logic       sync;
    len_e       len;
    logic       spare;
    logic [3:0] dst;
  } hdr_t;

  // phase length is tick+2 clock cycles
  typedef logic [2:0] tick_t;

  // number of payload bits for a length code
  function automatic logic [5:0] len_bits(input len_e len);
    logic [5:0] n;
    case (len)
      LEN_8:   n = 6'd8;
      LEN_16:  n = 6'd16;
      LEN_32:  n = 6'd32;
      default: n = 6'd0;
    endcase
    return n;
  endfunction

endpackage

//--- rtl/xcom_loc_exec.sv
// applies local commands to the board id and link tick registers and acks each request once
`timescale 1ns/1ps

module xcom_loc_exec (
  input  logic                  i_clk,
  input  logic                  c_rst_ni,
  input  logic                  i_req,
  input  xcom_cmd_pkg::cmd_t    i_cmd,
  output logic                  o_ack,
  output logic [3:0]            o_board_id,
  output xcom_link_pkg::tick_t  o_cfg_tick
);

  import xcom_cmd_pkg::*;

  logic req_q;
  logic req_new;

  // level stays up one cycle past the ack
  // so act only on the rising edge
  assign req_new = i_req & ~req_q;

  always_ff @(posedge i_clk) begin
    if (!c_rst_ni) begin
      req_q      <= 1'b0;
      o_ack      <= 1'b0;
      o_board_id <= 4'd0;
      o_cfg_tick <= '0;
    end else begin
      req_q <= i_req;
      o_ack <= req_new;
      if (req_new) begin
        case (i_cmd.op)
          OP_SET_ID: begin
            o_board_id <= i_cmd.data[3:0];
          end
          OP_SET_TICK: begin
            // new phase length applies from the next frame
            o_cfg_tick <= i_cmd.data[2:0];
          end
          default: begin
            // nothing else reaches this path, ack anyway
          end
        endcase
      end
    end
  end

endmodule

//--- rtl/xcom_tx.sv
// serializes one network command as header plus payload on the xcom data and clock lines
`timescale 1ns/1ps

module xcom_tx (
  input  logic                  i_clk,
  input  logic                  c_rst_ni,
  input  logic                  i_req,
  input  xcom_cmd_pkg::cmd_t    i_cmd,
  input  xcom_link_pkg::tick_t  i_cfg_tick,
  output logic                  o_ack,
  output logic                  o_ready,
  output logic                  o_xcom_data,
  output logic                  o_xcom_clk
);

  import xcom_cmd_pkg::*;
  import xcom_link_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SHIFT,
    ST_DONE
  } tx_state_e;

  tx_state_e   state_q;
  len_e        len;
  hdr_t        hdr;
  logic [31:0] data_al;
  logic [39:0] frame;
  logic [39:0] sr_q;
  logic [5:0]  bit_cnt_q;
  logic [3:0]  tick_cnt_q;
  logic [3:0]  phase_last;
  logic        phase_end;

  ////////////////////////////////////////////////////////////
  // frame assembly
  ////////////////////////////////////////////////////////////

  // length code sits in the opcode low bits
  assign len = len_e'(i_cmd.op[1:0]);

  always_comb begin
    hdr.sync  = 1'b0;
    hdr.len   = len;
    hdr.spare = 1'b0;
    hdr.dst   = i_cmd.dst;
  end

  // payload left aligned so the MSB goes out right after the header
  always_comb begin
    case (len)
      LEN_8:   data_al = {i_cmd.data[7:0], 24'd0};
      LEN_16:  data_al = {i_cmd.data[15:0], 16'd0};
      LEN_32:  data_al = i_cmd.data;
      default: data_al = 32'd0;
    endcase
  end

  assign frame = {hdr, data_al};

  ////////////////////////////////////////////////////////////
  // link clock divider
  ////////////////////////////////////////////////////////////

  // phase is tick+2 cycles, counter runs 0..tick+1
  assign phase_last = {1'b0, i_cfg_tick} + 4'd1;
  assign phase_end  = (tick_cnt_q == phase_last);

  ////////////////////////////////////////////////////////////
  // shift FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (!c_rst_ni) begin
      state_q     <= ST_IDLE;
      o_ack       <= 1'b0;
      o_ready     <= 1'b1;
      o_xcom_data <= 1'b0;
      o_xcom_clk  <= 1'b0;
      bit_cnt_q   <= 6'd0;
      tick_cnt_q  <= 4'd0;
    end else begin
      o_ack <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (i_req) begin
            // first bit valid for the whole first low phase
            o_xcom_data <= frame[39];
            bit_cnt_q   <= 6'd7 + len_bits(len);
            tick_cnt_q  <= 4'd0;
            o_ready     <= 1'b0;
            state_q     <= ST_SHIFT;
          end
        end
        ST_SHIFT: begin
          tick_cnt_q <= phase_end ? 4'd0 : tick_cnt_q + 4'd1;
          if (phase_end && !o_xcom_clk) begin
            // rising edge, receiver samples here
            o_xcom_clk <= 1'b1;
          end else if (phase_end && o_xcom_clk) begin
            o_xcom_clk <= 1'b0;
            if (bit_cnt_q == 6'd0) begin
              // last high phase over
              o_xcom_data <= 1'b0;
              o_ack       <= 1'b1;
              o_ready     <= 1'b1;
              state_q     <= ST_DONE;
            end else begin
              o_xcom_data <= sr_q[39];
              bit_cnt_q   <= bit_cnt_q - 6'd1;
            end
          end
        end
        ST_DONE: begin
          // request is still high during the ack cycle
          state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // remaining bits, shifted once at the start of each low phase
  always_ff @(posedge i_clk) begin
    if (state_q == ST_IDLE && i_req) begin
      sr_q <= frame << 1;
    end else if (state_q == ST_SHIFT && phase_end && o_xcom_clk) begin
      sr_q <= sr_q << 1;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the xcom command front end simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_xcom_cmd -f build.f -o sim_xcom
./obj_dir/sim_xcom 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  exit 1
fi
exit 0

//--- tb/tb_xcom_cmd.sv
// self-checking testbench for the xcom command front end, run as the simulation top
`timescale 1ns/1ps

module tb_xcom_cmd;

  import xcom_cmd_pkg::*;

  localparam int CNT_W  = 4;
  localparam int N_CMDS = 42;
  // longest frame is 40 bits of two phases at 9 cycles each
  localparam int LIMIT  = N_CMDS * 40 * 2 * 9 + 5000;

  // one decoded or expected frame
  typedef struct packed {
    logic [7:0]  hdr;
    logic [31:0] data;
  } frame_t;

  logic i_clk = 1'b0;
  logic c_rst_ni;
  logic i_tproc_en;
  logic [4:0] i_tproc_op;
  logic [31:0] i_tproc_data0, i_tproc_data1;
  logic [5:0] i_ps_ctrl;
  logic [31:0] i_ps_data0, i_ps_data1;
  logic o_xcom_data, o_xcom_clk, o_ready;
  logic [3:0] o_board_id;
  xcom_link_pkg::tick_t o_cfg_tick;
  logic [2*CNT_W-1:0] o_cmd_cnt;

  frame_t      exp_q[$];
  logic [31:0] lfsr = 32'h175c_ec56;
  logic [7:0]  c_cnt = 8'd0;
  logic [7:0]  p_cnt = 8'd0;
  logic [2:0]  tick_exp = 3'd0;
  int          cycles = 0;

  // decoder state
  logic        clk_prev = 1'b0;
  logic        edge_seen = 1'b0;
  int          run = 0;
  logic [5:0]  bit_cnt = 6'd0;
  logic [7:0]  rx_hdr;
  logic [31:0] rx_data;
  frame_t      exp_f;

  always #2 i_clk = ~i_clk;

  xcom_cmd_top #(.CNT_W(CNT_W)) u_dut (.*);

  bind xcom_cmd_top xcom_cmd_sva #(.CNT_W(CNT_W)) u_sva (
    .i_clk(i_clk), .c_rst_ni(c_rst_ni),
    .i_c_pending(c_pending), .i_p_pending(p_pending),
    .i_loc_req(loc_req), .i_net_req(net_req),
    .i_loc_ack(loc_ack), .i_net_ack(net_ack),
    .i_ready(o_ready), .i_xcom_clk(o_xcom_clk), .i_xcom_data(o_xcom_data),
    .i_board_id(o_board_id), .i_cfg_tick(o_cfg_tick), .i_cmd_cnt(o_cmd_cnt)
  );

  task automatic fail(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopping on first error");
  endtask

  ////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////

  // payload bits per header length code
  function automatic logic [5:0] bits_for(input logic [1:0] len);
    case (len)
      2'd1:    return 6'd8;
      2'd2:    return 6'd16;
      2'd3:    return 6'd32;
      default: return 6'd0;
    endcase
  endfunction

  function automatic frame_t expect_frame(input logic [4:0] op, input logic [31:0] d0,
                                          input logic [31:0] d1);
    frame_t f;
    f.hdr = {1'b0, op[1:0], 1'b0, d0[3:0]};
    case (op[1:0])
      2'd1:    f.data = {24'd0, d1[7:0]};
      2'd2:    f.data = {16'd0, d1[15:0]};
      2'd3:    f.data = d1;
      default: f.data = 32'd0;
    endcase
    return f;
  endfunction

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] next_rand();
    logic        fb;
    logic [31:0] v;
    v = 32'd0;
    for (int i = 0; i < 32; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic drive_pair(input logic c_en, input logic [4:0] c_op,
                            input logic [31:0] c_d0, input logic [31:0] c_d1,
                            input logic p_en, input logic [4:0] p_op,
                            input logic [31:0] p_d0, input logic [31:0] p_d1);
    @(posedge i_clk);
    #1;
    i_tproc_en    = c_en;
    i_tproc_op    = c_op;
    i_tproc_data0 = c_d0;
    i_tproc_data1 = c_d1;
    i_ps_ctrl     = {p_op, p_en};
    i_ps_data0    = p_d0;
    i_ps_data1    = p_d1;
    @(posedge i_clk);
    #1;
    i_tproc_en = 1'b0;
    i_ps_ctrl  = 6'd0;
  endtask

  // model of an accepted command
  task automatic book(input bit from_c, input logic [4:0] op, input logic [31:0] d0,
                      input logic [31:0] d1);
    if (from_c) c_cnt++;
    else p_cnt++;
    // phase length seen by every later frame
    if (op == OP_SET_TICK) tick_exp = d1[2:0];
    if (op[4:2] == 3'b001) exp_q.push_back(expect_frame(op, d0, d1));
  endtask

  task automatic issue_with(input bit from_c, input logic [4:0] op, input logic [31:0] d0,
                            input logic [31:0] d1, input bit accepted);
    if (from_c) drive_pair(1'b1, op, d0, d1, 1'b0, 5'd0, 32'd0, 32'd0);
    else drive_pair(1'b0, 5'd0, 32'd0, 32'd0, 1'b1, op, d0, d1);
    if (accepted) book(from_c, op, d0, d1);
  endtask

  task automatic issue(input bit from_c, input logic [4:0] op, input bit accepted);
    logic [31:0] d0, d1;
    d0 = next_rand();
    d1 = next_rand();
    issue_with(from_c, op, d0, d1, accepted);
  endtask

  task automatic wait_idle();
    do begin
      @(posedge i_clk);
      #1;
    end while (!(exp_q.size() == 0 && o_ready && !u_dut.c_pending && !u_dut.p_pending &&
                 !u_dut.net_req && !u_dut.loc_req));
  endtask

  task automatic wait_loc_ack();
    do begin
      @(posedge i_clk);
      #1;
    end while (!u_dut.loc_ack);
  endtask

  task automatic check_counts();
    assert (o_cmd_cnt == {c_cnt[3:0], p_cnt[3:0]})
      else fail($sformatf("o_cmd_cnt %h, expected %h", o_cmd_cnt, {c_cnt[3:0], p_cnt[3:0]}));
  endtask

  ////////////////////////////////////////////////////////////
  // serial decoder and phase checker
  ////////////////////////////////////////////////////////////

  always @(posedge i_clk) begin
    if (!c_rst_ni) begin
      edge_seen = 1'b0;
      bit_cnt   = 6'd0;
      clk_prev  = 1'b0;
    end else begin
      if (o_xcom_clk != clk_prev) begin
        // each phase between two link clock edges
        if (edge_seen) begin
          assert (run == int'(tick_exp) + 2)
            else fail($sformatf("link clock phase %0d cycles, expected %0d", run,
                                int'(tick_exp) + 2));
        end
        edge_seen = 1'b1;
        run       = 1;
        if (o_xcom_clk) begin
          if (bit_cnt == 6'd0) rx_data = 32'd0;
          if (bit_cnt < 6'd8) rx_hdr = {rx_hdr[6:0], o_xcom_data};
          else rx_data = {rx_data[30:0], o_xcom_data};
          bit_cnt++;
          if (bit_cnt >= 6'd8 && bit_cnt == 6'd8 + bits_for(rx_hdr[6:5])) begin
            assert (exp_q.size() > 0) else fail("a frame came out with no command expected");
            exp_f = exp_q.pop_front();
            assert (rx_hdr == exp_f.hdr)
              else fail($sformatf("header %h, expected %h", rx_hdr, exp_f.hdr));
            assert (rx_data == exp_f.data)
              else fail($sformatf("data %h, expected %h", rx_data, exp_f.data));
            bit_cnt = 6'd0;
          end
        end
      end else begin
        run++;
      end
      // frame over, next low phase has no leading edge
      if (o_ready && !o_xcom_clk) edge_seen = 1'b0;
      clk_prev = o_xcom_clk;
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout: the run went past %0d clock cycles", LIMIT);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    c_rst_ni      = 1'b0;
    i_tproc_en    = 1'b0;
    i_tproc_op    = 5'd0;
    i_tproc_data0 = 32'd0;
    i_tproc_data1 = 32'd0;
    i_ps_ctrl     = 6'd0;
    i_ps_data0    = 32'd0;
    i_ps_data1    = 32'd0;
    repeat (5) @(posedge i_clk);
    #1;
    c_rst_ni = 1'b1;

    // every length from both sources
    for (int k = 4; k < 8; k++) begin
      issue(1'b1, 5'(k), 1'b1);
      wait_idle();
      issue(1'b0, 5'(k), 1'b1);
      wait_idle();
    end
    check_counts();

    // local registers, then frames at the new phase length
    issue_with(1'b1, OP_SET_TICK, 32'd0, 32'hffff_fff3, 1'b1);
    wait_loc_ack();
    assert (o_cfg_tick == 3'd3) else fail($sformatf("o_cfg_tick %0d, expected 3", o_cfg_tick));
    issue_with(1'b0, OP_SET_ID, 32'd0, 32'h1234_567a, 1'b1);
    wait_loc_ack();
    assert (o_board_id == 4'ha) else fail($sformatf("o_board_id %h, expected a", o_board_id));
    issue(1'b0, OP_SEND32, 1'b1);
    wait_idle();
    issue(1'b1, OP_SEND8, 1'b1);
    wait_idle();
    issue_with(1'b1, OP_SET_TICK, 32'd0, 32'd7, 1'b1);
    wait_loc_ack();
    assert (o_cfg_tick == 3'd7) else fail($sformatf("o_cfg_tick %0d, expected 7", o_cfg_tick));
    issue(1'b0, OP_SEND16, 1'b1);
    wait_idle();
    issue_with(1'b0, OP_SET_TICK, 32'd0, 32'd0, 1'b1);
    wait_loc_ack();
    check_counts();

    // simultaneous strobes, processor goes first
    begin
      logic [31:0] a0, a1, b0, b1;
      a0 = next_rand();
      a1 = next_rand();
      b0 = next_rand();
      b1 = next_rand();
      drive_pair(1'b1, OP_SEND16, a0, a1, 1'b1, OP_SEND8, b0, b1);
      book(1'b1, OP_SEND16, a0, a1);
      book(1'b0, OP_SEND8, b0, b1);
    end
    wait_idle();
    check_counts();

    // busy transmitter, both captures fill and extra strobes drop
    issue(1'b1, OP_SEND32, 1'b1);
    do begin
      @(posedge i_clk);
      #1;
    end while (o_ready);
    issue(1'b1, OP_SEND8, 1'b1);
    issue(1'b1, OP_SEND16, 1'b0);
    issue(1'b0, OP_SEND0, 1'b1);
    issue(1'b0, OP_SEND32, 1'b0);
    wait_idle();
    check_counts();

    // nop and an unused code change nothing
    issue(1'b0, OP_NOP, 1'b0);
    issue(1'b1, 5'd3, 1'b0);
    wait_idle();
    check_counts();

    // enough short frames to wrap both counters
    for (int k = 0; k < 9; k++) begin
      issue(1'b1, OP_SEND0, 1'b1);
      wait_idle();
      issue(1'b0, OP_SEND0, 1'b1);
      wait_idle();
    end
    check_counts();

    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- tb/xcom_cmd_sva.sv
// protocol assertions for the xcom command front end, bound into the top level by the testbench
`timescale 1ns/1ps

module xcom_cmd_sva #(
  parameter int CNT_W = 4
) (
  input logic                 i_clk,
  input logic                 c_rst_ni,
  input logic                 i_c_pending,
  input logic                 i_p_pending,
  input logic                 i_loc_req,
  input logic                 i_net_req,
  input logic                 i_loc_ack,
  input logic                 i_net_ack,
  input logic                 i_ready,
  input logic                 i_xcom_clk,
  input logic                 i_xcom_data,
  input logic [3:0]           i_board_id,
  input xcom_link_pkg::tick_t i_cfg_tick,
  input logic [2*CNT_W-1:0]   i_cmd_cnt
);

  import xcom_link_pkg::*;

  ////////////////////////////////////////////////////////////
  // request and acknowledge
  ////////////////////////////////////////////////////////////

  // transmitter busy from the cycle after the request until its ack
  a_ready_low: assert property (@(posedge i_clk) disable iff (!c_rst_ni)
    (i_net_req && !i_net_ack && $past(i_net_req)) |-> !i_ready)
    else $error("o_ready high during a network request");

  a_net_hold: assert property (@(posedge i_clk) disable iff (!c_rst_ni)
    (i_net_req && !i_net_ack) |=> i_net_req)
    else $error("network request dropped before ack");

  a_loc_hold: assert property (@(posedge i_clk) disable iff (!c_rst_ni)
    (i_loc_req && !i_loc_ack) |=> i_loc_req)
    else $error("local request dropped before ack");

  // acks are single cycle pulses
  a_net_ack_pulse: assert property (@(posedge i_clk) disable iff (!c_rst_ni)
    i_net_ack |=> !i_net_ack)
    else $error("network ack longer than one cycle");

  a_loc_ack_pulse: assert property (@(posedge i_clk) disable iff (!c_rst_ni)
    i_loc_ack |=> !i_loc_ack)
    else $error("local ack longer than one cycle");

  a_one_req: assert property (@(posedge i_clk) disable iff (!c_rst_ni)
    !(i_loc_req && i_net_req))
    else $error("local and network request both high");

  // link clock parked while idle
  a_clk_idle: assert property (@(posedge i_clk) disable iff (!c_rst_ni)
    i_ready |-> !i_xcom_clk)
    else $error("link clock active while ready");

  ////////////////////////////////////////////////////////////
  // reset values
  ////////////////////////////////////////////////////////////

  a_reset: assert property (@(posedge i_clk)
    !c_rst_ni |=> (!i_c_pending && !i_p_pending && !i_loc_req && !i_net_req &&
                   !i_loc_ack && !i_net_ack && !i_xcom_clk && !i_xcom_data && i_ready &&
                   i_board_id == 4'd0 && i_cfg_tick == tick_t'(0) && i_cmd_cnt == '0))
    else $error("controls not at reset values");

endmodule
